// File: Makefile
TOOL     = verilator
FLAGS    = --binary --timing
LINT     = --lint-only --timing
TOP      = decode_tb
FILELIST = decode_stage.f
OBJDIR   = obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

run: build
	./$(OBJDIR)/V$(TOP) | tee /dev/stderr | grep -q "NO ERRORS"

lint:
	$(TOOL) $(LINT) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJDIR)

// File: common/decode_macros.svh
`ifndef DECODE_MACROS_SVH
`define DECODE_MACROS_SVH

// RV32I major opcodes
`define OP_R        7'b0110011
`define OP_LOAD     7'b0000011
`define OP_IMM      7'b0010011
`define OP_JALR     7'b1100111
`define OP_LUI      7'b0110111
`define OP_AUIPC    7'b0010111
`define OP_JAL      7'b1101111
`define OP_BRANCH   7'b1100011
`define OP_STORE    7'b0100011
`define OP_SYSTEM   7'b1110011

`define ALU_ADD     4'd0
`define ALU_SUB     4'd1
`define ALU_SLT     4'd2
`define ALU_SLTU    4'd3
`define ALU_XOR     4'd4
`define ALU_OR      4'd5
`define ALU_AND     4'd6
`define ALU_SLL     4'd7
`define ALU_SRL     4'd8
`define ALU_SRA     4'd9
`define ALU_EQ      4'd10

// how execute widens the raw immediate
`define IMM_12I     2'd0
`define IMM_5U      2'd1
`define IMM_20U     2'd2
`define IMM_20I     2'd3

`define SRC1_REG    2'd0
`define SRC1_PC     2'd1
`define SRC1_ZERO   2'd2

`define SRC2_IMM    2'd0
`define SRC2_REG    2'd1
`define SRC2_CSRS   2'd2
`define SRC2_CSRW   2'd3

`define CSR_MEPC    12'h341
`define CSR_MCAUSE  12'h342
`define CSR_MSTATUS 12'h300
`define CSR_MTVEC   12'h305

`define ECALL_CAUSE 32'd11
`define ECALL_WORD  32'h0000_0073
`define MRET_WORD   32'h3020_0073

`endif

// File: common/decode_pkg.sv
package decode_pkg;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm_11_0;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0] imm_11_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_4_0;
        logic [6:0] opcode;
    } s_fmt_t;

    typedef struct packed {
        logic       imm_12;
        logic [5:0] imm_10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm_4_1;
        logic       imm_11;
        logic [6:0] opcode;
    } b_fmt_t;

    typedef struct packed {
        logic [19:0] imm_31_12;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } u_fmt_t;

    typedef struct packed {
        logic       imm_20;
        logic [9:0] imm_10_1;
        logic       imm_11;
        logic [7:0] imm_19_12;
        logic [4:0] rd;
        logic [6:0] opcode;
    } j_fmt_t;

    // one instruction word, six views
    typedef union packed {
        logic [31:0] raw;
        r_fmt_t      r_fmt;
        i_fmt_t      i_fmt;
        s_fmt_t      s_fmt;
        b_fmt_t      b_fmt;
        u_fmt_t      u_fmt;
        j_fmt_t      j_fmt;
    } inst_u;

    typedef struct packed {
        logic       mem_wen;
        logic       mem_ren;
        logic [1:0] src1_sel;
        logic [1:0] src2_sel;
        logic       inv_flag;
        logic       branch_flag;
        logic       jump_flag;
        logic [1:0] imm_kind;
        logic [3:0] alu_op;
        logic       reg_wen;
        logic [3:0] csr_wen;     // mtvec, mstatus, mcause, mepc
        logic       ecall_flag;
        logic       mret_flag;
        logic [2:0] funct3;
        logic [4:0] rd;
    } ctrl_t;

    typedef struct packed {
        logic [31:0] rs1_value;
        logic [31:0] rs2_value;
        logic [31:0] csr_value;
        logic [31:0] imm;
        logic [31:0] pc;
        logic [31:0] inst;
    } operand_t;

    typedef struct packed {
        logic [4:0]  rd;
        logic [31:0] rd_value;
        logic        reg_wen;
        logic [3:0]  csr_wen;
        logic [31:0] csr_data;
    } wb_t;

endpackage

// File: decode/ctrl_decode.sv
`timescale 1ns/1ns
`include "decode_macros.svh"

module ctrl_decode import decode_pkg::*; (
    input  inst_u       inst_q,
    input  logic [31:0] imm,
    output ctrl_t       ctrl
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic       alt;       // funct7 selects sub / sra
    logic       is_sys;
    logic [3:0] alu_op;

    // shared by register and immediate arithmetic
    function automatic logic [3:0] arith_op(input logic [2:0] f3,
                                            input logic       sub_sel,
                                            input logic       sra_sel);
        case (f3)
            3'b000:  arith_op = sub_sel ? `ALU_SUB : `ALU_ADD;
            3'b001:  arith_op = `ALU_SLL;
            3'b010:  arith_op = `ALU_SLT;
            3'b011:  arith_op = `ALU_SLTU;
            3'b100:  arith_op = `ALU_XOR;
            3'b101:  arith_op = sra_sel ? `ALU_SRA : `ALU_SRL;
            3'b110:  arith_op = `ALU_OR;
            default: arith_op = `ALU_AND;
        endcase
    endfunction

    assign opcode = inst_q.r_fmt.opcode;
    assign funct3 = inst_q.r_fmt.funct3;
    assign alt    = (inst_q.r_fmt.funct7 != 7'd0);
    assign is_sys = (opcode == `OP_SYSTEM);

    always_comb begin
        case (opcode)
            `OP_R:   alu_op = arith_op(funct3, alt, alt);
            `OP_IMM: alu_op = arith_op(funct3, 1'b0, alt);
            `OP_BRANCH: begin
                case (funct3[2:1])
                    2'b00:   alu_op = `ALU_EQ;     // beq, bne
                    2'b10:   alu_op = `ALU_SLT;
                    2'b11:   alu_op = `ALU_SLTU;
                    default: alu_op = `ALU_ADD;
                endcase
            end
            `OP_SYSTEM: alu_op = (funct3 == 3'b010) ? `ALU_OR : `ALU_ADD;  // csrrs sets bits
            default: alu_op = `ALU_ADD;
        endcase
    end

    always_comb begin
        ctrl = '0;    // imm_kind is filled in from imm_gen at the top

        ctrl.funct3  = funct3;
        ctrl.rd      = inst_q.r_fmt.rd;
        ctrl.alu_op  = alu_op;
        ctrl.reg_wen = !(opcode == `OP_STORE || opcode == `OP_BRANCH ||
                         inst_q.raw == 32'd0);
        ctrl.mem_wen = (opcode == `OP_STORE);
        ctrl.mem_ren = (opcode == `OP_LOAD);

        ctrl.jump_flag   = (opcode == `OP_JAL || opcode == `OP_JALR);
        ctrl.branch_flag = (opcode == `OP_BRANCH);
        // beq, bge, bgeu take the inverted compare
        ctrl.inv_flag    = (opcode == `OP_BRANCH) &&
                           (funct3 == 3'b000 || funct3 == 3'b101 || funct3 == 3'b111);

        ctrl.csr_wen[0] = is_sys && (imm == {20'd0, `CSR_MEPC});
        ctrl.csr_wen[1] = is_sys && (imm == {20'd0, `CSR_MCAUSE});
        ctrl.csr_wen[2] = is_sys && (imm == {20'd0, `CSR_MSTATUS});
        ctrl.csr_wen[3] = is_sys && (imm == {20'd0, `CSR_MTVEC});

        ctrl.ecall_flag = (inst_q.raw == `ECALL_WORD);
        ctrl.mret_flag  = (inst_q.raw == `MRET_WORD);

        if (opcode == `OP_LUI)
            ctrl.src1_sel = `SRC1_ZERO;
        else if (opcode == `OP_JAL || opcode == `OP_AUIPC)
            ctrl.src1_sel = `SRC1_PC;
        else
            ctrl.src1_sel = `SRC1_REG;

        if (opcode == `OP_R || opcode == `OP_BRANCH)
            ctrl.src2_sel = `SRC2_REG;
        else if (is_sys && funct3 == 3'b010)
            ctrl.src2_sel = `SRC2_CSRS;
        else if (is_sys && funct3 == 3'b001)
            ctrl.src2_sel = `SRC2_CSRW;
        else
            ctrl.src2_sel = `SRC2_IMM;
    end

endmodule

// File: decode/decode_latch.sv
`timescale 1ns/1ns

module decode_latch import decode_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        in_valid,
    input  logic [31:0] inst,
    input  logic [31:0] pc,
    input  logic        flush,
    input  logic        stall,
    output logic        in_ready,
    input  logic        out_ready,
    output logic        out_valid,
    output inst_u       inst_q,
    output logic [31:0] pc_q
);

    logic xfer;
    logic flush_q;
    logic stall_q;
    logic flush_hit;
    logic stall_hit;

    assign in_ready  = out_ready;    // no skid buffer
    assign xfer      = in_valid & in_ready;
    assign flush_hit = flush | flush_q;
    assign stall_hit = stall | stall_q;

    // requests seen between transfers are held until the next one
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            flush_q <= 1'b0;
            stall_q <= 1'b0;
        end else if (xfer) begin
            flush_q <= 1'b0;
            stall_q <= 1'b0;
        end else begin
            if (flush)
                flush_q <= 1'b1;
            if (stall)
                stall_q <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n)
            out_valid <= 1'b0;
        else if (xfer && flush_hit)
            out_valid <= 1'b0;
        else if (in_ready)
            out_valid <= in_valid;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            inst_q <= '0;
            pc_q   <= '0;
        end else if (xfer) begin
            if (flush_hit)
                inst_q <= '0;             // bubble, decodes to no writes
            else if (!stall_hit)
                inst_q.raw <= inst;
            if (!stall_hit)
                pc_q <= pc;
        end
    end

endmodule

// File: decode/imm_gen.sv
`timescale 1ns/1ns
`include "decode_macros.svh"

module imm_gen import decode_pkg::*; (
    input  inst_u       inst_q,
    output logic [31:0] imm,
    output logic [1:0]  imm_kind
);

    logic [6:0] opcode;
    logic       shift_imm;

    assign opcode    = inst_q.r_fmt.opcode;
    assign shift_imm = (opcode == `OP_IMM) &&
                       (inst_q.i_fmt.funct3 == 3'b001 || inst_q.i_fmt.funct3 == 3'b101);

    // raw fields only, execute does the widening
    always_comb begin
        case (opcode)
            `OP_R:      imm = {25'd0, inst_q.r_fmt.funct7};
            `OP_LOAD, `OP_IMM, `OP_JALR, `OP_SYSTEM:
                        imm = {20'd0, inst_q.i_fmt.imm_11_0};
            `OP_LUI, `OP_AUIPC:
                        imm = {12'd0, inst_q.u_fmt.imm_31_12};
            `OP_JAL:    imm = {12'd0, inst_q.j_fmt.imm_20, inst_q.j_fmt.imm_19_12,
                               inst_q.j_fmt.imm_11, inst_q.j_fmt.imm_10_1};
            `OP_BRANCH: imm = {{19{inst_q.b_fmt.imm_12}}, inst_q.b_fmt.imm_12,
                               inst_q.b_fmt.imm_11, inst_q.b_fmt.imm_10_5,
                               inst_q.b_fmt.imm_4_1, 1'b0};
            `OP_STORE:  imm = {20'd0, inst_q.s_fmt.imm_11_5, inst_q.s_fmt.imm_4_0};
            default:    imm = 32'd0;
        endcase
    end

    always_comb begin
        if (opcode == `OP_LUI || opcode == `OP_AUIPC)
            imm_kind = `IMM_20U;
        else if (opcode == `OP_JAL)
            imm_kind = `IMM_20I;
        else if (shift_imm)
            imm_kind = `IMM_5U;     // shamt only
        else
            imm_kind = `IMM_12I;
    end

endmodule

// File: decode_stage.f
+incdir+common
common/decode_pkg.sv
decode/decode_latch.sv
decode/imm_gen.sv
decode/ctrl_decode.sv
source/reg_csr_file.sv
source/decode_top.sv
testbench/decode_tb.sv

// File: source/decode_top.sv
`timescale 1ns/1ns

module decode_top import decode_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        in_valid,
    input  logic [31:0] inst,
    input  logic [31:0] pc,
    input  logic        flush,
    input  logic        stall,
    input  logic        out_ready,
    input  wb_t         wb,
    output logic        in_ready,
    output logic        out_valid,
    output ctrl_t       ctrl,
    output operand_t    ops,
    output logic [4:0]  rs1,
    output logic [4:0]  rs2,
    output logic [31:0] a0_value,
    output logic [31:0] mepc_out,
    output logic [31:0] mtvec_out
);

    inst_u       inst_q;
    logic [31:0] pc_q;
    logic [31:0] imm;
    logic [1:0]  imm_kind;
    ctrl_t       ctrl_dec;
    logic [31:0] rs1_value;
    logic [31:0] rs2_value;
    logic [31:0] csr_value;
    logic        ecall_valid;

    decode_latch latch_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .inst      (inst),
        .pc        (pc),
        .flush     (flush),
        .stall     (stall),
        .in_ready  (in_ready),
        .out_ready (out_ready),
        .out_valid (out_valid),
        .inst_q    (inst_q),
        .pc_q      (pc_q)
    );

    imm_gen imm_i (.inst_q(inst_q), .imm(imm), .imm_kind(imm_kind));

    ctrl_decode ctrl_i (.inst_q(inst_q), .imm(imm), .ctrl(ctrl_dec));

    always_comb begin
        ctrl          = ctrl_dec;
        ctrl.imm_kind = imm_kind;
    end

    assign rs1         = inst_q.r_fmt.rs1;
    assign rs2         = inst_q.r_fmt.rs2;
    assign ecall_valid = ctrl_dec.ecall_flag & out_valid;  // bubbles never trap

    reg_csr_file rf_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .rs1         (rs1),
        .rs2         (rs2),
        .csr_addr    (imm[11:0]),
        .pc          (pc_q),
        .ecall_valid (ecall_valid),
        .wb          (wb),
        .rs1_value   (rs1_value),
        .rs2_value   (rs2_value),
        .csr_value   (csr_value),
        .a0_value    (a0_value),
        .mepc_out    (mepc_out),
        .mtvec_out   (mtvec_out)
    );

    assign ops.rs1_value = rs1_value;
    assign ops.rs2_value = rs2_value;
    assign ops.csr_value = csr_value;
    assign ops.imm       = imm;
    assign ops.pc        = pc_q;
    assign ops.inst      = inst_q.raw;

endmodule

// File: source/reg_csr_file.sv
`timescale 1ns/1ns
`include "decode_macros.svh"

module reg_csr_file import decode_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  logic [4:0]  rs1,
    input  logic [4:0]  rs2,
    input  logic [11:0] csr_addr,
    input  logic [31:0] pc,
    input  logic        ecall_valid,
    input  wb_t         wb,
    output logic [31:0] rs1_value,
    output logic [31:0] rs2_value,
    output logic [31:0] csr_value,
    output logic [31:0] a0_value,
    output logic [31:0] mepc_out,
    output logic [31:0] mtvec_out
);

    logic [31:0] regs [0:31];
    logic [31:0] mepc;
    logic [31:0] mcause;
    logic [31:0] mstatus;
    logic [31:0] mtvec;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < 32; i++)
                regs[i] <= 32'd0;
        end else if (wb.reg_wen && wb.rd != 5'd0) begin
            regs[wb.rd] <= wb.rd_value;
        end
    end

    // no bypass, a same-cycle write is seen next cycle
    assign rs1_value = (rs1 == 5'd0) ? 32'd0 : regs[rs1];
    assign rs2_value = (rs2 == 5'd0) ? 32'd0 : regs[rs2];
    assign a0_value  = regs[10];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mepc    <= 32'd0;
            mcause  <= 32'd0;
            mstatus <= 32'd0;
            mtvec   <= 32'd0;
        end else begin
            if (ecall_valid)
                mepc <= pc;              // trap wins over writeback
            else if (wb.csr_wen[0])
                mepc <= wb.csr_data;
            if (ecall_valid)
                mcause <= `ECALL_CAUSE;
            else if (wb.csr_wen[1])
                mcause <= wb.csr_data;
            if (wb.csr_wen[2])
                mstatus <= wb.csr_data;
            if (wb.csr_wen[3])
                mtvec <= wb.csr_data;
        end
    end

    always_comb begin
        case (csr_addr)
            `CSR_MEPC:    csr_value = mepc;
            `CSR_MCAUSE:  csr_value = mcause;
            `CSR_MSTATUS: csr_value = mstatus;
            `CSR_MTVEC:   csr_value = mtvec;
            default:      csr_value = 32'd0;
        endcase
    end

    assign mepc_out  = mepc;
    assign mtvec_out = mtvec;

endmodule

// File: testbench/decode_tb.sv
`timescale 1ns/1ns
`include "decode_macros.svh"

module decode_tb import decode_pkg::*; ();

    localparam int MAX_CYCLES = 2000;

    logic        clk = 1'b0;
    logic        rst_n;
    logic        in_valid;
    logic [31:0] inst;
    logic [31:0] pc;
    logic        flush;
    logic        stall;
    logic        out_ready;
    wb_t         wb;
    logic        in_ready;
    logic        out_valid;
    ctrl_t       ctrl;
    operand_t    ops;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [31:0] a0_value;
    logic [31:0] mepc_out;
    logic [31:0] mtvec_out;

    integer      seed = 86597;
    int          cycles = 0;
    int          checks = 0;
    int          errors = 0;
    logic [31:0] exp_regs [0:31];

    decode_top dut_i (.*);

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("run timed out after %0d cycles", cycles);
            $display("ERRORS FOUND");
            $finish;
        end
    end

    task automatic check_ctrl(input ctrl_t got, input ctrl_t exp, input string msg);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Error at %0t: %s ctrl %h, expected %h", $time, msg, got, exp);
        end
    endtask

    task automatic check_ops(input operand_t got, input operand_t exp, input string msg);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Error at %0t: %s ops %h, expected %h", $time, msg, got, exp);
        end
    endtask

    task automatic check_word(input logic [31:0] got, input logic [31:0] exp,
                              input string msg);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Error at %0t: %s got %h, expected %h", $time, msg, got, exp);
        end
    endtask

    // reference decode, from the instruction set rules
    function automatic ctrl_t expect_ctrl(input logic [31:0] w);
        ctrl_t      c;
        logic [6:0] op;
        logic [2:0] f3;
        c  = '0;
        op = w[6:0];
        f3 = w[14:12];
        c.funct3      = f3;
        c.rd          = w[11:7];
        c.reg_wen     = !(op == `OP_STORE || op == `OP_BRANCH || w == 32'd0);
        c.mem_wen     = (op == `OP_STORE);
        c.mem_ren     = (op == `OP_LOAD);
        c.jump_flag   = (op == `OP_JAL || op == `OP_JALR);
        c.branch_flag = (op == `OP_BRANCH);
        c.inv_flag    = (op == `OP_BRANCH) && (f3 == 3'd0 || f3 == 3'd5 || f3 == 3'd7);
        if (op == `OP_SYSTEM) begin
            case (w[31:20])
                `CSR_MEPC:    c.csr_wen = 4'b0001;
                `CSR_MCAUSE:  c.csr_wen = 4'b0010;
                `CSR_MSTATUS: c.csr_wen = 4'b0100;
                `CSR_MTVEC:   c.csr_wen = 4'b1000;
                default:      c.csr_wen = 4'b0000;
            endcase
        end
        c.ecall_flag = (w == 32'h0000_0073);
        c.mret_flag  = (w == 32'h3020_0073);
        c.src1_sel = (op == `OP_LUI) ? `SRC1_ZERO :
                     (op == `OP_JAL || op == `OP_AUIPC) ? `SRC1_PC : `SRC1_REG;
        if (op == `OP_R || op == `OP_BRANCH)
            c.src2_sel = 2'd1;
        else if (op == `OP_SYSTEM && f3 == 3'd2)
            c.src2_sel = 2'd2;
        else if (op == `OP_SYSTEM && f3 == 3'd1)
            c.src2_sel = 2'd3;
        if (op == `OP_LUI || op == `OP_AUIPC)
            c.imm_kind = `IMM_20U;
        else if (op == `OP_JAL)
            c.imm_kind = `IMM_20I;
        else if (op == `OP_IMM && (f3 == 3'd1 || f3 == 3'd5))
            c.imm_kind = `IMM_5U;
        c.alu_op = `ALU_ADD;
        if (op == `OP_R || op == `OP_IMM) begin
            case (f3)
                3'd0: c.alu_op = (op == `OP_R && w[31:25] != 0) ? `ALU_SUB : `ALU_ADD;
                3'd1: c.alu_op = `ALU_SLL;
                3'd2: c.alu_op = `ALU_SLT;
                3'd3: c.alu_op = `ALU_SLTU;
                3'd4: c.alu_op = `ALU_XOR;
                3'd5: c.alu_op = (w[31:25] != 0) ? `ALU_SRA : `ALU_SRL;
                3'd6: c.alu_op = `ALU_OR;
                3'd7: c.alu_op = `ALU_AND;
            endcase
        end else if (op == `OP_BRANCH) begin
            c.alu_op = (f3 < 3'd2) ? `ALU_EQ : (f3 < 3'd6) ? `ALU_SLT : `ALU_SLTU;
        end else if (op == `OP_SYSTEM && f3 == 3'd2) begin
            c.alu_op = `ALU_OR;
        end
        return c;
    endfunction

    function automatic logic [31:0] expect_imm(input logic [31:0] w);
        case (w[6:0])
            `OP_R:    return {25'd0, w[31:25]};
            `OP_LOAD, `OP_IMM, `OP_JALR, `OP_SYSTEM:
                      return {20'd0, w[31:20]};
            `OP_LUI, `OP_AUIPC:
                      return {12'd0, w[31:12]};
            `OP_JAL:  return {12'd0, w[31], w[19:12], w[20], w[30:21]};
            `OP_BRANCH:
                      return {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
            `OP_STORE:
                      return {20'd0, w[31:25], w[11:7]};
            default:  return 32'd0;
        endcase
    endfunction

    // starts and ends on a falling edge
    task automatic transfer(input logic [31:0] w, input logic [31:0] p);
        in_valid = 1'b1;
        inst     = w;
        pc       = p;
        while (!in_ready)
            @(negedge clk);
        @(negedge clk);
        in_valid = 1'b0;
    endtask

    task automatic write_back(input wb_t w);
        wb = w;
        @(negedge clk);
        wb = '0;
    endtask

    task automatic report(input string name, input int errs_before);
        if (errors == errs_before)
            $display("test %s: pass", name);
        else
            $display("test %s: fail, %0d mismatches", name, errors - errs_before);
    endtask

    task automatic test_handshake();
        int e;
        e = errors;
        check_word({31'd0, out_valid}, 32'd0, "out_valid after reset");
        check_ctrl(ctrl, expect_ctrl(32'd0), "ctrl after reset");
        transfer(32'h0050_0093, 32'h100);           // addi x1, x0, 5
        check_word({31'd0, out_valid}, 32'd1, "out_valid after transfer");
        out_ready = 1'b0;
        in_valid  = 1'b1;
        inst      = 32'h0000_0013;
        #1;
        check_word({31'd0, in_ready}, 32'd0, "in_ready follows out_ready");
        repeat (2) @(negedge clk);
        check_word({31'd0, out_valid}, 32'd1, "out_valid hold");
        check_word(ops.inst, 32'h0050_0093, "inst hold");
        out_ready = 1'b1;
        in_valid  = 1'b0;
        @(negedge clk);
        report("handshake", e);
    endtask

    task automatic decode_one(input logic [31:0] w);
        operand_t exp;
        transfer(w, 32'h200);
        exp           = '0;    // csrs still at reset here
        exp.rs1_value = exp_regs[w[19:15]];
        exp.rs2_value = exp_regs[w[24:20]];
        exp.imm       = expect_imm(w);
        exp.inst      = w;
        exp.pc        = 32'h200;
        check_ctrl(ctrl, expect_ctrl(w), $sformatf("decode %h", w));
        check_ops(ops, exp, $sformatf("imm %h", w));
    endtask

    task automatic test_decode();
        int          e;
        logic [31:0] w;
        logic [6:0]  ops_list [0:5];
        e = errors;
        ops_list = '{`OP_LOAD, `OP_STORE, `OP_JAL, `OP_JALR, `OP_LUI, `OP_AUIPC};
        for (int f = 0; f < 8; f++) begin
            w = $random(seed);
            decode_one({7'd0, w[24:15], f[2:0], w[11:7], `OP_R});
            w = $random(seed);
            decode_one({7'd0, w[24:15], f[2:0], w[11:7], `OP_IMM});
        end
        decode_one({7'h20, 10'h0a5, 3'd0, 5'd3, `OP_R});      // sub
        decode_one({7'h20, 10'h0a5, 3'd5, 5'd3, `OP_R});      // sra
        decode_one({7'h20, 10'h0a5, 3'd5, 5'd3, `OP_IMM});    // srai
        foreach (ops_list[k]) begin
            w = $random(seed);
            w[6:0] = ops_list[k];
            decode_one(w);
        end
        for (int f = 0; f < 8; f++) begin
            if (f == 2 || f == 3)
                continue;
            w = $random(seed);
            decode_one({w[31:15], f[2:0], w[11:7], `OP_BRANCH});
        end
        decode_one({`CSR_MTVEC, 5'd2, 3'd1, 5'd0, `OP_SYSTEM});   // csrrw
        decode_one({`CSR_MEPC, 5'd2, 3'd2, 5'd1, `OP_SYSTEM});    // csrrs
        decode_one({`CSR_MCAUSE, 5'd2, 3'd2, 5'd1, `OP_SYSTEM});
        decode_one({`CSR_MSTATUS, 5'd2, 3'd1, 5'd0, `OP_SYSTEM});
        report("decode", e);
    endtask

    task automatic test_regs();
        int e;
        e = errors;
        exp_regs[0] = 32'd0;
        for (int i = 1; i < 32; i++) begin
            exp_regs[i] = $random(seed);
            write_back('{rd: i[4:0], rd_value: exp_regs[i], reg_wen: 1'b1,
                         csr_wen: 4'd0, csr_data: 32'd0});
        end
        write_back('{rd: 5'd0, rd_value: 32'hdead_beef, reg_wen: 1'b1,
                     csr_wen: 4'd0, csr_data: 32'd0});
        for (int i = 0; i < 32; i++) begin
            transfer({7'd0, 5'(31 - i), 5'(i), 3'd0, 5'd1, `OP_R}, 32'h300);
            check_word({27'd0, rs1}, i, $sformatf("rs1 number %0d", i));
            check_word({27'd0, rs2}, 31 - i, $sformatf("rs2 number %0d", 31 - i));
            check_word(ops.rs1_value, exp_regs[i], $sformatf("rs1 x%0d", i));
            check_word(ops.rs2_value, exp_regs[31 - i], $sformatf("rs2 x%0d", 31 - i));
        end
        check_word(a0_value, exp_regs[10], "a0_value");
        report("regs", e);
    endtask

    task automatic read_csr(input logic [11:0] addr, input logic [31:0] exp);
        transfer({addr, 5'd0, 3'd2, 5'd1, `OP_SYSTEM}, 32'h400);
        check_word(ops.csr_value, exp, $sformatf("csr %h", addr));
    endtask

    task automatic test_csrs();
        int          e;
        logic [31:0] vals [0:3];
        logic [11:0] addrs [0:3];
        e = errors;
        addrs = '{`CSR_MEPC, `CSR_MCAUSE, `CSR_MSTATUS, `CSR_MTVEC};
        for (int k = 0; k < 4; k++) begin
            vals[k] = $random(seed);
            write_back('{rd: 5'd0, rd_value: 32'd0, reg_wen: 1'b0,
                         csr_wen: 4'(1 << k), csr_data: vals[k]});
        end
        for (int k = 0; k < 4; k++)
            read_csr(addrs[k], vals[k]);
        read_csr(12'h123, 32'd0);
        check_word(mepc_out, vals[0], "mepc_out");
        check_word(mtvec_out, vals[3], "mtvec_out");
        report("csrs", e);
    endtask

    task automatic test_ecall_mret();
        int e;
        e = errors;
        write_back('{rd: 5'd0, rd_value: 32'd0, reg_wen: 1'b0,
                     csr_wen: 4'b0001, csr_data: 32'h0000_0c00});
        transfer(32'h0000_0073, 32'h0000_0a40);
        check_ctrl(ctrl, expect_ctrl(32'h0000_0073), "ecall decode");
        check_word(mepc_out, 32'h0000_0c00, "mepc before edge");
        // writeback to mepc and mcause in the same cycle loses to the trap
        write_back('{rd: 5'd0, rd_value: 32'd0, reg_wen: 1'b0,
                     csr_wen: 4'b0011, csr_data: 32'h0000_0d00});
        check_word(mepc_out, 32'h0000_0a40, "mepc after ecall");
        read_csr(`CSR_MCAUSE, `ECALL_CAUSE);
        transfer(32'h3020_0073, 32'h0000_0b00);
        check_ctrl(ctrl, expect_ctrl(32'h3020_0073), "mret decode");
        check_word({31'd0, ctrl.mret_flag}, 32'd1, "mret_flag");
        check_word({27'd0, ctrl.rd}, 32'd0, "mret rd");
        report("ecall_mret", e);
    endtask

    task automatic test_flush_stall();
        int e;
        e = errors;
        flush = 1'b1;
        transfer(32'h0010_0093, 32'h500);
        flush = 1'b0;
        check_word({31'd0, out_valid}, 32'd0, "flush out_valid");
        check_ctrl(ctrl, expect_ctrl(32'd0), "flush ctrl");
        check_word(ops.inst, 32'd0, "flush inst");
        transfer(32'h0020_0113, 32'h504);
        check_word({31'd0, out_valid}, 32'd1, "after flush out_valid");
        check_word(ops.inst, 32'h0020_0113, "after flush inst");
        stall = 1'b1;
        transfer(32'h0030_0193, 32'h508);
        stall = 1'b0;
        check_word({31'd0, out_valid}, 32'd1, "stall out_valid");
        check_word(ops.inst, 32'h0020_0113, "stall inst");
        check_word(ops.pc, 32'h504, "stall pc");
        transfer(32'h0040_0213, 32'h50c);
        check_word(ops.inst, 32'h0040_0213, "after stall inst");
        check_word(ops.pc, 32'h50c, "after stall pc");
        // sticky request raised with no transfer
        stall = 1'b1;
        @(negedge clk);
        stall = 1'b0;
        transfer(32'h0050_0293, 32'h510);
        check_word(ops.inst, 32'h0040_0213, "sticky stall inst");
        transfer(32'h0060_0313, 32'h514);
        check_word(ops.inst, 32'h0060_0313, "stall cleared");
        flush = 1'b1;
        @(negedge clk);
        flush = 1'b0;
        transfer(32'h0070_0393, 32'h518);
        check_word({31'd0, out_valid}, 32'd0, "sticky flush out_valid");
        check_word(ops.inst, 32'd0, "sticky flush inst");
        transfer(32'h0080_0413, 32'h51c);
        check_word({31'd0, out_valid}, 32'd1, "flush cleared");
        report("flush_stall", e);
    endtask

    initial begin
        rst_n     = 1'b0;
        in_valid  = 1'b0;
        inst      = 32'd0;
        pc        = 32'd0;
        flush     = 1'b0;
        stall     = 1'b0;
        out_ready = 1'b1;
        wb        = '0;
        foreach (exp_regs[i])
            exp_regs[i] = 32'd0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        test_handshake();
        test_decode();
        test_regs();
        test_csrs();
        test_ecall_mret();
        test_flush_stall();
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0)
            $display("NO ERRORS");
        else
            $display("ERRORS FOUND");
        $finish;
    end

endmodule
